/* dv/arith_ex_patterns.txt */
# issue line: per lane v op br jalr uimm imm rs1 rs2 pc pred al rd urd, lane0 | lane1 | al_head
# expect line: wb_data0 wb_data1 | slot0 fv mp tk target pc al | slot1 fv mp tk target pc al
1 0 0 0 0 0 5 7 100 0 1 3 1 | 1 0 0 0 1 fffffffc 10 0 104 0 2 4 1 | 0
c c | 0 0 0 0 0 0 | 0 0 0 0 0 0
1 1 0 0 0 0 3 5 108 0 3 5 1 | 1 2 0 0 1 f0ff ff0f 0 10c 0 4 6 1 | 0
fffffffe f00f | 0 0 0 0 0 0 | 0 0 0 0 0 0
1 3 0 0 0 0 a0 b 110 0 5 7 1 | 1 4 0 0 1 f ff 0 114 0 6 8 1 | 0
ab f0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
1 5 0 0 0 0 ffffffff 1 118 0 7 9 1 | 1 6 0 0 0 0 ffffffff 1 11c 0 8 a 1 | 0
1 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
1 5 0 0 1 fffffff0 3 0 120 0 9 b 1 | 1 6 0 0 1 fffffff0 3 0 124 0 a c 1 | 0
0 1 | 0 0 0 0 0 0 | 0 0 0 0 0 0
1 7 0 0 0 0 1 24 128 0 b d 1 | 1 8 0 0 1 4 80000000 0 12c 0 c e 1 | 0
10 8000000 | 0 0 0 0 0 0 | 0 0 0 0 0 0
1 9 0 0 0 0 80000000 4 130 0 d f 1 | 1 9 0 0 1 2 fffffff0 0 134 0 e 10 1 | 0
f8000000 fffffffc | 0 0 0 0 0 0 | 0 0 0 0 0 0
1 a 0 0 0 2000 55 66 1000 0 f 11 1 | 1 a 0 0 1 fffff000 0 0 138 0 10 12 1 | 0
3000 fffff138 | 0 0 0 0 0 0 | 0 0 0 0 0 0
1 0 1 0 0 40 5 5 200 1 11 0 0 | 1 0 2 0 0 80 5 5 204 1 12 0 0 | 0
a a | 1 1 0 284 204 12 | 1 0 1 240 200 11
1 0 3 0 0 10 ffffffff 1 300 0 13 0 0 | 1 0 4 0 0 20 ffffffff 1 304 0 14 0 0 | 0
0 0 | 1 1 1 310 300 13 | 1 0 0 324 304 14
1 0 5 0 0 8 ffffffff 1 400 1 15 0 0 | 1 0 6 0 0 fffffff8 ffffffff 1 404 1 16 0 0 | 0
0 0 | 1 1 0 408 400 15 | 1 0 1 3fc 404 16
1 0 0 0 1 1 1 0 500 0 17 1 1 | 1 0 1 0 0 c 1 2 504 0 18 0 0 | 0
2 3 | 1 0 0 510 504 18 | 0 0 0 0 0 0
1 0 0 1 1 4 1000 0 600 0 2 1 1 | 1 0 2 0 0 40 1 2 604 0 1f 0 0 | 1e
604 3 | 1 1 1 644 604 1f | 1 1 1 1004 600 2
1 0 1 0 0 8 7 7 700 0 1d 0 0 | 1 0 0 1 1 fffffffc 2000 0 704 0 3 2 1 | 1c
e 708 | 1 1 1 708 700 1d | 1 1 1 1ffc 704 3
0 0 1 0 0 8 1 1 800 0 4 0 0 | 1 0 0 0 0 0 2 3 804 0 5 3 1 | 0
0 5 | 0 0 0 0 0 0 | 0 0 0 0 0 0
1 0 4 0 0 10 5 5 900 1 6 0 0 | 0 0 0 0 0 0 0 0 0 0 0 0 0 | 0
a 0 | 1 0 1 910 900 6 | 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 0 0 | 0
0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
1 0 5 0 0 20 1 ffffffff a00 1 7 0 0 | 1 0 6 0 0 30 1 ffffffff a04 0 8 0 0 | 0
0 0 | 1 0 1 a20 a00 7 | 1 0 0 a34 a04 8

/* dv/arith_ex_props.sv */
`timescale 1ns/1ps

module arith_ex_props import ex_pkg::*; (
    input logic  clk,
    input logic  i_reset,
    input logic  i_valid [lanes],
    input logic  i_wb_ready,
    input logic  o_ready,
    input logic  o_wb_valid [lanes],
    input word_t o_wb_data [lanes],
    input logic  o_fb_valid [lanes],
    input logic  o_fb_mispredict [lanes],
    input word_t o_fb_target [lanes]
);

    logic busy;
    logic held;

    assign busy = o_wb_valid[0] || o_wb_valid[1];

    // occupancy as seen from the issue and writeback handshakes
    always_ff @(posedge clk) begin
        if (i_reset) begin
            held <= 1'b0;
        end else if (!held || i_wb_ready) begin
            held <= i_valid[0] || i_valid[1];
        end
    end

    reset_clears: assert property (@(posedge clk)
        i_reset |=> !busy && !o_fb_valid[0] && !o_fb_valid[1])
        else $error("output valid set right after reset");

    // held contents under back-pressure
    hold_stable: assert property (@(posedge clk) disable iff (i_reset)
        busy && !i_wb_ready |=> $stable(o_wb_data[0]) && $stable(o_wb_data[1]) &&
        $stable(o_wb_valid[0]) && $stable(o_wb_valid[1]) &&
        $stable(o_fb_valid[0]) && $stable(o_fb_valid[1]) &&
        $stable(o_fb_mispredict[0]) && $stable(o_fb_target[0]))
        else $error("outputs changed while stalled");

    ready_rule: assert property (@(posedge clk) disable iff (i_reset)
        !o_ready |-> held && !i_wb_ready)
        else $error("o_ready low while the stage could move");

endmodule

bind arith_ex_top arith_ex_props u_props (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_valid         (i_valid),
    .i_wb_ready      (i_wb_ready),
    .o_ready         (o_ready),
    .o_wb_valid      (o_wb_valid),
    .o_wb_data       (o_wb_data),
    .o_fb_valid      (o_fb_valid),
    .o_fb_mispredict (o_fb_mispredict),
    .o_fb_target     (o_fb_target)
);

/* dv/arith_ex_tb.sv */
`timescale 1ns/1ps

module arith_ex_tb import ex_pkg::*; ();

    // one record is a lane0 block, a lane1 block, the head and the expected results
    localparam int lane_cols = 13;
    localparam int head_col = 26;
    localparam int data_col = 27;
    localparam int slot_col = 29;
    localparam int ncol = 41;

    logic                  clk;
    logic                  i_reset;
    logic                  i_valid [lanes];
    alu_op_t               i_alu_op [lanes];
    br_op_t                i_br_op [lanes];
    logic                  i_is_jalr [lanes];
    logic                  i_uses_imm [lanes];
    word_t                 i_imm [lanes];
    word_t                 i_rs1 [lanes];
    word_t                 i_rs2 [lanes];
    word_t                 i_pc [lanes];
    logic                  i_pred_taken [lanes];
    al_addr_t              i_al_addr [lanes];
    logic [reg_addr_w-1:0] i_rd [lanes];
    logic                  i_uses_rd [lanes];
    al_addr_t              i_al_head;
    logic                  i_wb_ready;
    logic                  o_ready;
    logic                  o_wb_valid [lanes];
    logic [reg_addr_w-1:0] o_wb_rd [lanes];
    logic                  o_wb_uses_rd [lanes];
    al_addr_t              o_wb_al_idx [lanes];
    word_t                 o_wb_data [lanes];
    logic                  o_fb_valid [lanes];
    logic                  o_fb_mispredict [lanes];
    logic                  o_fb_taken [lanes];
    word_t                 o_fb_target [lanes];
    word_t                 o_fb_pc [lanes];
    al_addr_t              o_fb_al_addr [lanes];

    word_t       vals [$];
    int          exp_q [$];
    int          npat;
    int          ptr;
    int          head_p;
    logic        loaded;
    logic        expect_new;
    logic [31:0] rng;

    arith_ex_top UUT (
        .clk(clk), .i_reset(i_reset), .i_valid(i_valid), .i_alu_op(i_alu_op),
        .i_br_op(i_br_op), .i_is_jalr(i_is_jalr), .i_uses_imm(i_uses_imm),
        .i_imm(i_imm), .i_rs1(i_rs1), .i_rs2(i_rs2), .i_pc(i_pc),
        .i_pred_taken(i_pred_taken), .i_al_addr(i_al_addr), .i_rd(i_rd),
        .i_uses_rd(i_uses_rd), .i_al_head(i_al_head), .i_wb_ready(i_wb_ready),
        .o_ready(o_ready), .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd),
        .o_wb_uses_rd(o_wb_uses_rd), .o_wb_al_idx(o_wb_al_idx), .o_wb_data(o_wb_data),
        .o_fb_valid(o_fb_valid), .o_fb_mispredict(o_fb_mispredict),
        .o_fb_taken(o_fb_taken), .o_fb_target(o_fb_target), .o_fb_pc(o_fb_pc),
        .o_fb_al_addr(o_fb_al_addr)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int hex_val(input byte c);
        int ci;
        ci = int'(c);
        if (ci >= 48 && ci <= 57) begin
            return ci - 48;
        end else if (ci >= 97 && ci <= 102) begin
            return ci - 87;
        end else if (ci >= 65 && ci <= 70) begin
            return ci - 55;
        end
        return -1;
    endfunction

    function automatic word_t field(input int p, input int c);
        return vals[p * ncol + c];
    endfunction

    function automatic logic bit_at(input int p, input int c);
        word_t w;
        w = field(p, c);
        return w[0];
    endfunction

    task automatic fail_value(input string name, input word_t got, input word_t exp_v);
        $display("** Error: %s got %h expected %h", name, got, exp_v);
        $display("test failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp_v);
        assert (got === exp_v) else fail_value(name, got, exp_v);
    endtask

    // hex tokens separated by anything else, lines starting with # are skipped
    task automatic load_patterns();
        int    fd;
        int    n;
        int    d;
        logic  in_tok;
        word_t acc;
        string line;
        fd = $fopen("dv/arith_ex_patterns.txt", "r");
        if (fd == 0) begin
            fail_plain("cannot open the pattern file dv/arith_ex_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && int'(line.getc(0)) != 35) begin
                    in_tok = 1'b0;
                    acc = '0;
                    for (int i = 0; i < line.len(); i++) begin
                        d = hex_val(line.getc(i));
                        if (d >= 0) begin
                            acc = (acc << 4) | word_t'(d);
                            in_tok = 1'b1;
                        end else if (in_tok) begin
                            vals.push_back(acc);
                            acc = '0;
                            in_tok = 1'b0;
                        end
                    end
                    if (in_tok) begin
                        vals.push_back(acc);
                    end
                end
            end
            $fclose(fd);
            npat = vals.size() / ncol;
            if (vals.size() % ncol != 0 || npat == 0) begin
                fail_plain("the pattern file holds no complete set of records");
            end
        end
    endtask

    task automatic drive_pattern(input int p);
        int    b;
        word_t w;
        for (int l = 0; l < lanes; l++) begin
            b = l * lane_cols;
            if (p < npat) begin
                i_valid[l] <= bit_at(p, b);
                w = field(p, b + 1);
                i_alu_op[l] <= alu_op_t'(w[3:0]);
                w = field(p, b + 2);
                i_br_op[l] <= br_op_t'(w[2:0]);
                i_is_jalr[l] <= bit_at(p, b + 3);
                i_uses_imm[l] <= bit_at(p, b + 4);
                i_imm[l] <= field(p, b + 5);
                i_rs1[l] <= field(p, b + 6);
                i_rs2[l] <= field(p, b + 7);
                i_pc[l] <= field(p, b + 8);
                i_pred_taken[l] <= bit_at(p, b + 9);
                w = field(p, b + 10);
                i_al_addr[l] <= w[al_addr_w-1:0];
                w = field(p, b + 11);
                i_rd[l] <= w[reg_addr_w-1:0];
                i_uses_rd[l] <= bit_at(p, b + 12);
            end else begin
                i_valid[l] <= 1'b0;
            end
        end
        if (p < npat) begin
            w = field(p, head_col);
            i_al_head <= w[al_addr_w-1:0];
        end
    endtask

    task automatic check_pair(input int p);
        int b;
        int s;
        for (int l = 0; l < lanes; l++) begin
            b = l * lane_cols;
            s = slot_col + l * 6;
            compare_word($sformatf("o_wb_valid[%0d]", l), word_t'(o_wb_valid[l]),
                         word_t'(bit_at(p, b)));
            if (bit_at(p, b)) begin
                compare_word($sformatf("o_wb_data[%0d]", l), o_wb_data[l],
                             field(p, data_col + l));
                compare_word($sformatf("o_wb_rd[%0d]", l), word_t'(o_wb_rd[l]),
                             field(p, b + 11));
                compare_word($sformatf("o_wb_uses_rd[%0d]", l), word_t'(o_wb_uses_rd[l]),
                             field(p, b + 12));
                compare_word($sformatf("o_wb_al_idx[%0d]", l), word_t'(o_wb_al_idx[l]),
                             field(p, b + 10));
            end
            compare_word($sformatf("o_fb_valid[%0d]", l), word_t'(o_fb_valid[l]),
                         field(p, s));
            if (bit_at(p, s)) begin
                compare_word($sformatf("o_fb_mispredict[%0d]", l),
                             word_t'(o_fb_mispredict[l]), field(p, s + 1));
                compare_word($sformatf("o_fb_taken[%0d]", l), word_t'(o_fb_taken[l]),
                             field(p, s + 2));
                compare_word($sformatf("o_fb_target[%0d]", l), o_fb_target[l],
                             field(p, s + 3));
                compare_word($sformatf("o_fb_pc[%0d]", l), o_fb_pc[l], field(p, s + 4));
                compare_word($sformatf("o_fb_al_addr[%0d]", l), word_t'(o_fb_al_addr[l]),
                             field(p, s + 5));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        i_reset = 1'b1;
        i_wb_ready = 1'b0;
        i_al_head = '0;
        for (int l = 0; l < lanes; l++) begin
            i_valid[l] = 1'b0;
            i_alu_op[l] = alu_add;
            i_br_op[l] = br_none;
            i_is_jalr[l] = 1'b0;
            i_uses_imm[l] = 1'b0;
            i_imm[l] = '0;
            i_rs1[l] = '0;
            i_rs2[l] = '0;
            i_pc[l] = '0;
            i_pred_taken[l] = 1'b0;
            i_al_addr[l] = '0;
            i_rd[l] = '0;
            i_uses_rd[l] = 1'b0;
        end
        loaded = 1'b0;
        expect_new = 1'b0;
        ptr = 0;
        npat = 0;
        rng = 32'd12436;
        load_patterns();
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        i_reset <= 1'b0;
        i_wb_ready <= 1'b1;
        drive_pattern(0);
    end

    // all DUT state changes land in the NBA region, so this block sees pre-edge values
    always @(posedge clk) begin
        if (!i_reset && loaded) begin
            // the stage holds a pair exactly while the queue is not empty
            compare_word("o_ready", word_t'(o_ready),
                         word_t'(exp_q.size() == 0 || i_wb_ready));
            if (expect_new) begin
                assert ((o_wb_valid[0] || o_wb_valid[1]) && exp_q.size() == 1)
                    else fail_plain("an accepted pair did not appear one cycle later");
            end
            if ((o_wb_valid[0] || o_wb_valid[1]) && i_wb_ready) begin
                assert (exp_q.size() != 0)
                    else fail_plain("the DUT delivered a pair that was never issued");
                head_p = exp_q.pop_front();
                check_pair(head_p);
            end
            expect_new = 1'b0;
            if (o_ready && ptr < npat) begin
                if (bit_at(ptr, 0) || bit_at(ptr, lane_cols)) begin
                    exp_q.push_back(ptr);
                    expect_new = 1'b1;
                end
                ptr = ptr + 1;
                drive_pattern(ptr);
            end
            // roughly one stall cycle in four
            i_wb_ready <= (rng[1:0] != 2'b00);
            rng = xorshift(rng);
            if (ptr >= npat && exp_q.size() == 0) begin
                $display("test passed");
                $finish;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (npat * 20 + 16) @(posedge clk);
        fail_plain("timeout: the run did not complete in the allowed number of cycles");
    end

endmodule

/* list.f */
logic/ex_pkg.sv
logic/ex_operand_decode.sv
logic/ex_alu_lane.sv
logic/ex_branch_order.sv
logic/ex_result_stage.sv
logic/arith_ex_top.sv
dv/arith_ex_props.sv
dv/arith_ex_tb.sv

/* logic/arith_ex_top.sv */
`timescale 1ns/1ps

module arith_ex_top import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_valid [lanes],
    input  alu_op_t               i_alu_op [lanes],
    input  br_op_t                i_br_op [lanes],
    input  logic                  i_is_jalr [lanes],
    input  logic                  i_uses_imm [lanes],
    input  word_t                 i_imm [lanes],
    input  word_t                 i_rs1 [lanes],
    input  word_t                 i_rs2 [lanes],
    input  word_t                 i_pc [lanes],
    input  logic                  i_pred_taken [lanes],
    input  al_addr_t              i_al_addr [lanes],
    input  logic [reg_addr_w-1:0] i_rd [lanes],
    input  logic                  i_uses_rd [lanes],
    input  al_addr_t              i_al_head,
    input  logic                  i_wb_ready,
    output logic                  o_ready,
    output logic                  o_wb_valid [lanes],
    output logic [reg_addr_w-1:0] o_wb_rd [lanes],
    output logic                  o_wb_uses_rd [lanes],
    output al_addr_t              o_wb_al_idx [lanes],
    output word_t                 o_wb_data [lanes],
    output logic                  o_fb_valid [lanes],
    output logic                  o_fb_mispredict [lanes],
    output logic                  o_fb_taken [lanes],
    output word_t                 o_fb_target [lanes],
    output word_t                 o_fb_pc [lanes],
    output al_addr_t              o_fb_al_addr [lanes]
);

    word_t op_a [lanes];
    word_t op_b [lanes];
    logic  is_branch [lanes];
    word_t lane_data [lanes];
    word_t lane_target [lanes];
    logic  lane_taken [lanes];
    logic  lane_mispredict [lanes];
    logic  swap;

    for (genvar l = 0; l < lanes; l++) begin : g_lane
        ex_operand_decode u_decode (
            .i_uses_imm  (i_uses_imm[l]),
            .i_imm       (i_imm[l]),
            .i_rs1       (i_rs1[l]),
            .i_rs2       (i_rs2[l]),
            .i_alu_op    (i_alu_op[l]),
            .i_br_op     (i_br_op[l]),
            .i_is_jalr   (i_is_jalr[l]),
            .o_op_a      (op_a[l]),
            .o_op_b      (op_b[l]),
            .o_is_branch (is_branch[l])
        );

        ex_alu_lane u_alu (
            .i_op_a       (op_a[l]),
            .i_op_b       (op_b[l]),
            .i_rs1        (i_rs1[l]),
            .i_rs2        (i_rs2[l]),
            .i_imm        (i_imm[l]),
            .i_pc         (i_pc[l]),
            .i_alu_op     (i_alu_op[l]),
            .i_br_op      (i_br_op[l]),
            .i_is_jalr    (i_is_jalr[l]),
            .i_pred_taken (i_pred_taken[l]),
            .o_data       (lane_data[l]),
            .o_target     (lane_target[l]),
            .o_taken      (lane_taken[l]),
            .o_mispredict (lane_mispredict[l])
        );
    end

    ex_branch_order u_order (
        .i_is_branch  (is_branch),
        .i_mispredict (lane_mispredict),
        .i_al_addr    (i_al_addr),
        .i_al_head    (i_al_head),
        .o_swap       (swap)
    );

    ex_result_stage u_result (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_valid         (i_valid),
        .i_is_branch     (is_branch),
        .i_data          (lane_data),
        .i_target        (lane_target),
        .i_pc            (i_pc),
        .i_taken         (lane_taken),
        .i_mispredict    (lane_mispredict),
        .i_rd            (i_rd),
        .i_uses_rd       (i_uses_rd),
        .i_al_addr       (i_al_addr),
        .i_swap          (swap),
        .i_wb_ready      (i_wb_ready),
        .o_ready         (o_ready),
        .o_wb_valid      (o_wb_valid),
        .o_wb_rd         (o_wb_rd),
        .o_wb_uses_rd    (o_wb_uses_rd),
        .o_wb_al_idx     (o_wb_al_idx),
        .o_wb_data       (o_wb_data),
        .o_fb_valid      (o_fb_valid),
        .o_fb_mispredict (o_fb_mispredict),
        .o_fb_taken      (o_fb_taken),
        .o_fb_target     (o_fb_target),
        .o_fb_pc         (o_fb_pc),
        .o_fb_al_addr    (o_fb_al_addr)
    );

endmodule

/* logic/ex_alu_lane.sv */
`timescale 1ns/1ps

module ex_alu_lane import ex_pkg::*; (
    input  word_t   i_op_a,
    input  word_t   i_op_b,
    input  word_t   i_rs1,
    input  word_t   i_rs2,
    input  word_t   i_imm,
    input  word_t   i_pc,
    input  alu_op_t i_alu_op,
    input  br_op_t  i_br_op,
    input  logic    i_is_jalr,
    input  logic    i_pred_taken,
    output word_t   o_data,
    output word_t   o_target,
    output logic    o_taken,
    output logic    o_mispredict
);

    logic [shamt_w-1:0] shamt;
    word_t alu_res;
    logic  cond;
    logic  slt_s;
    logic  slt_u;

    assign shamt = i_op_b[shamt_w-1:0];
    assign slt_s = $signed(i_op_a) < $signed(i_op_b);
    assign slt_u = i_op_a < i_op_b;

    always_comb begin
        case (i_alu_op)
            alu_add:   alu_res = i_op_a + i_op_b;
            alu_sub:   alu_res = i_op_a - i_op_b;
            alu_and:   alu_res = i_op_a & i_op_b;
            alu_or:    alu_res = i_op_a | i_op_b;
            alu_xor:   alu_res = i_op_a ^ i_op_b;
            alu_slt:   alu_res = {{(xlen-1){1'b0}}, slt_s};
            alu_sltu:  alu_res = {{(xlen-1){1'b0}}, slt_u};
            alu_sll:   alu_res = i_op_a << shamt;
            alu_srl:   alu_res = i_op_a >> shamt;
            alu_sra:   alu_res = $signed(i_op_a) >>> shamt;
            // op_b holds the immediate here
            alu_auipc: alu_res = i_pc + i_op_b;
            default:   alu_res = '0;
        endcase
    end

    // branch compares always look at the raw registers
    always_comb begin
        case (i_br_op)
            br_beq:  cond = i_rs1 == i_rs2;
            br_bne:  cond = i_rs1 != i_rs2;
            br_blt:  cond = $signed(i_rs1) < $signed(i_rs2);
            br_bge:  cond = $signed(i_rs1) >= $signed(i_rs2);
            br_bltu: cond = i_rs1 < i_rs2;
            br_bgeu: cond = i_rs1 >= i_rs2;
            default: cond = 1'b0;
        endcase
    end

    assign o_taken = i_is_jalr || cond;
    assign o_target = i_is_jalr ? (i_rs1 + i_imm) : (i_pc + i_imm);

    // link value for jalr
    assign o_data = i_is_jalr ? (i_pc + word_t'(4)) : alu_res;

    // the front end never predicts a register target, so jalr always redirects
    assign o_mispredict = i_is_jalr ||
                          ((i_br_op != br_none) && (o_taken != i_pred_taken));

endmodule

/* logic/ex_branch_order.sv */
`timescale 1ns/1ps

module ex_branch_order import ex_pkg::*; (
    input  logic     i_is_branch [lanes],
    input  logic     i_mispredict [lanes],
    input  al_addr_t i_al_addr [lanes],
    input  al_addr_t i_al_head,
    output logic     o_swap
);

    al_addr_t age [lanes];
    logic both_branch;
    logic only_lane1;
    logic both_mp;
    logic one_mp;

    // distance from the head, the list size is a power of two so it wraps by itself
    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            age[l] = i_al_addr[l] - i_al_head;
        end
    end

    assign both_branch = i_is_branch[0] && i_is_branch[1];
    assign only_lane1 = i_is_branch[1] && !i_is_branch[0];
    assign both_mp = i_mispredict[0] && i_mispredict[1];
    assign one_mp = i_mispredict[0] != i_mispredict[1];

    always_comb begin
        o_swap = 1'b0;
        if (only_lane1) begin
            o_swap = 1'b1;
        end else if (both_branch) begin
            if (one_mp) begin
                o_swap = i_mispredict[1];
            end else if (both_mp) begin
                // older redirect wins slot 0
                o_swap = age[1] < age[0];
            end
        end
    end

endmodule

/* logic/ex_operand_decode.sv */
`timescale 1ns/1ps

module ex_operand_decode import ex_pkg::*; (
    input  logic    i_uses_imm,
    input  word_t   i_imm,
    input  word_t   i_rs1,
    input  word_t   i_rs2,
    input  alu_op_t i_alu_op,
    input  br_op_t  i_br_op,
    input  logic    i_is_jalr,
    output word_t   o_op_a,
    output word_t   o_op_b,
    output logic    o_is_branch
);

    logic imm_sel;

    // auipc always pairs the pc with the immediate
    assign imm_sel = i_uses_imm || (i_alu_op == alu_auipc);

    assign o_op_a = i_rs1;
    assign o_op_b = imm_sel ? i_imm : i_rs2;

    // jalr reports through the branch feedback path as well
    assign o_is_branch = (i_br_op != br_none) || i_is_jalr;

endmodule

/* logic/ex_pkg.sv */
package ex_pkg;

    localparam int xlen = 32;
    localparam int al_size = 32;
    localparam int al_addr_w = $clog2(al_size);
    localparam int reg_addr_w = 5;
    localparam int shamt_w = 5;
    localparam int lanes = 2;

    typedef logic [xlen-1:0] word_t;
    typedef logic [al_addr_w-1:0] al_addr_t;

    // arithmetic operations executed by one lane
    typedef enum logic [3:0] {
        alu_add   = 4'd0,
        alu_sub   = 4'd1,
        alu_and   = 4'd2,
        alu_or    = 4'd3,
        alu_xor   = 4'd4,
        alu_slt   = 4'd5,
        alu_sltu  = 4'd6,
        alu_sll   = 4'd7,
        alu_srl   = 4'd8,
        alu_sra   = 4'd9,
        alu_auipc = 4'd10
    } alu_op_t;

    // conditional branch kinds, br_none for plain arithmetic
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_beq  = 3'd1,
        br_bne  = 3'd2,
        br_blt  = 3'd3,
        br_bge  = 3'd4,
        br_bltu = 3'd5,
        br_bgeu = 3'd6
    } br_op_t;

endpackage

/* logic/ex_result_stage.sv */
`timescale 1ns/1ps

module ex_result_stage import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_valid [lanes],
    input  logic                  i_is_branch [lanes],
    input  word_t                 i_data [lanes],
    input  word_t                 i_target [lanes],
    input  word_t                 i_pc [lanes],
    input  logic                  i_taken [lanes],
    input  logic                  i_mispredict [lanes],
    input  logic [reg_addr_w-1:0] i_rd [lanes],
    input  logic                  i_uses_rd [lanes],
    input  al_addr_t              i_al_addr [lanes],
    input  logic                  i_swap,
    input  logic                  i_wb_ready,
    output logic                  o_ready,
    output logic                  o_wb_valid [lanes],
    output logic [reg_addr_w-1:0] o_wb_rd [lanes],
    output logic                  o_wb_uses_rd [lanes],
    output al_addr_t              o_wb_al_idx [lanes],
    output word_t                 o_wb_data [lanes],
    output logic                  o_fb_valid [lanes],
    output logic                  o_fb_mispredict [lanes],
    output logic                  o_fb_taken [lanes],
    output word_t                 o_fb_target [lanes],
    output word_t                 o_fb_pc [lanes],
    output al_addr_t              o_fb_al_addr [lanes]
);

    logic fb_req [lanes];
    logic swap_eff;
    logic stage_full;
    int unsigned src [lanes];

    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            fb_req[l] = i_valid[l] && i_is_branch[l];
        end
    end

    // an idle lane may still carry stale branch fields
    assign swap_eff = (fb_req[0] && fb_req[1]) ? i_swap : (fb_req[1] && !fb_req[0]);

    always_comb begin
        src[0] = swap_eff ? 1 : 0;
        src[1] = swap_eff ? 0 : 1;
    end

    always_comb begin
        stage_full = 1'b0;
        for (int l = 0; l < lanes; l++) begin
            stage_full = stage_full || o_wb_valid[l];
        end
    end

    // one pair per cycle, refill on the draining edge
    assign o_ready = !stage_full || i_wb_ready;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int l = 0; l < lanes; l++) begin
                o_wb_valid[l] <= 1'b0;
                o_fb_valid[l] <= 1'b0;
            end
        end else if (o_ready) begin
            for (int l = 0; l < lanes; l++) begin
                o_wb_valid[l] <= i_valid[l];
                o_fb_valid[l] <= fb_req[src[l]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready) begin
            for (int l = 0; l < lanes; l++) begin
                o_wb_rd[l] <= i_rd[l];
                o_wb_uses_rd[l] <= i_uses_rd[l];
                o_wb_al_idx[l] <= i_al_addr[l];
                o_wb_data[l] <= i_data[l];
                o_fb_mispredict[l] <= i_mispredict[src[l]];
                o_fb_taken[l] <= i_taken[src[l]];
                o_fb_target[l] <= i_target[src[l]];
                o_fb_pc[l] <= i_pc[src[l]];
                o_fb_al_addr[l] <= i_al_addr[src[l]];
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the arith_ex testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f list.f \
    --top-module arith_ex_tb -o arith_ex_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/arith_ex_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
